//--- cps_a_regs.sv
// cps-a write-only video registers with byte-lane writes and the delayed palette copy and dma strobes
`timescale 1ns/100ps
`include "cps_params.svh"

module cps_a_regs (
    input  logic               clk,
    input  logic               reg_rst,
    input  logic               ppu1_cs,
    input  cps_pkg::mmr_addr_t addr,
    input  logic [1:0]         dsn,
    input  cps_pkg::word_t     cpu_dout,
    output cps_pkg::word_t     vram_obj_base,
    output cps_pkg::word_t     vram1_base,
    output cps_pkg::word_t     vram2_base,
    output cps_pkg::word_t     vram3_base,
    output cps_pkg::word_t     vram_row_base,
    output cps_pkg::word_t     pal_base,
    output cps_pkg::word_t     hpos1,
    output cps_pkg::word_t     hpos2,
    output cps_pkg::word_t     hpos3,
    output cps_pkg::word_t     vpos1,
    output cps_pkg::word_t     vpos2,
    output cps_pkg::word_t     vpos3,
    output cps_pkg::word_t     hstar1,
    output cps_pkg::word_t     hstar2,
    output cps_pkg::word_t     vstar1,
    output cps_pkg::word_t     vstar2,
    output cps_pkg::word_t     row_offset,
    output cps_pkg::word_t     ppu_ctrl,
    output logic               pal_copy,
    output logic               obj_dma_ok
);

    localparam int NREGS = `CPS_A_VIDEO_CTRL + 1;

    cps_pkg::word_t regs_q [NREGS];
    logic           pre_copy;
    logic           pre_dma_ok;

    // a lane whose dsn bit is high keeps its old byte
    function automatic cps_pkg::word_t merge(cps_pkg::word_t old_w, cps_pkg::word_t new_w,
                                             logic [1:0] sel_n);
        return {sel_n[1] ? old_w[15:8] : new_w[15:8], sel_n[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
            pre_copy   <= 1'b0;
            pre_dma_ok <= 1'b0;
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
        end else if (ppu1_cs) begin
            // offsets above the video control word are ignored
            if (addr <= `CPS_A_VIDEO_CTRL) begin
                regs_q[addr] <= merge(regs_q[addr], cpu_dout, dsn);
            end
            if (addr == `CPS_A_OBJ_BASE) begin
                pre_dma_ok <= 1'b1;
            end
            if (addr == `CPS_A_PAL_BASE) begin
                pre_copy <= 1'b1;
            end
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
        end else begin
            // requests wait for cs to drop so the video side reads the settled base
            pal_copy   <= pre_copy;
            obj_dma_ok <= pre_dma_ok;
            pre_copy   <= 1'b0;
            pre_dma_ok <= 1'b0;
        end
    end

    assign vram_obj_base = regs_q[`CPS_A_OBJ_BASE];
    assign vram1_base    = regs_q[`CPS_A_VRAM1_BASE];
    assign vram2_base    = regs_q[`CPS_A_VRAM2_BASE];
    assign vram3_base    = regs_q[`CPS_A_VRAM3_BASE];
    assign vram_row_base = regs_q[`CPS_A_ROW_BASE];
    assign pal_base      = regs_q[`CPS_A_PAL_BASE];
    assign hpos1         = regs_q[`CPS_A_HPOS1];
    assign vpos1         = regs_q[`CPS_A_VPOS1];
    assign hpos2         = regs_q[`CPS_A_HPOS2];
    assign vpos2         = regs_q[`CPS_A_VPOS2];
    assign hpos3         = regs_q[`CPS_A_HPOS3];
    assign vpos3         = regs_q[`CPS_A_VPOS3];
    assign hstar1        = regs_q[`CPS_A_HSTAR1];
    assign vstar1        = regs_q[`CPS_A_VSTAR1];
    assign hstar2        = regs_q[`CPS_A_HSTAR2];
    assign vstar2        = regs_q[`CPS_A_VSTAR2];
    assign row_offset    = regs_q[`CPS_A_ROW_OFFSET];
    assign ppu_ctrl      = regs_q[`CPS_A_VIDEO_CTRL];

    // the copy request never overlaps an access on the next cycle
    a_no_copy_during_cs: assert property (
        @(posedge clk) disable iff (reg_rst) ppu1_cs |=> !pal_copy);

endmodule

//--- cps_b_regs.sv
// cps-b registers at configurable addresses: id, multiplier, layer and priority control, extra inputs
`timescale 1ns/100ps
`include "cps_params.svh"

module cps_b_regs (
    input  logic                 clk,
    input  logic                 reg_rst,
    input  logic                 ppu2_cs,
    input  cps_pkg::mmr_addr_t   addr,
    input  logic [1:0]           dsn,
    input  cps_pkg::word_t       cpu_dout,
    input  cps_pkg::mmr_addr_t   addr_id,
    input  cps_pkg::mmr_addr_t   addr_mult1,
    input  cps_pkg::mmr_addr_t   addr_mult2,
    input  cps_pkg::mmr_addr_t   addr_rslt0,
    input  cps_pkg::mmr_addr_t   addr_rslt1,
    input  cps_pkg::mmr_addr_t   addr_layer,
    input  cps_pkg::mmr_addr_t   addr_prio0,
    input  cps_pkg::mmr_addr_t   addr_prio1,
    input  cps_pkg::mmr_addr_t   addr_prio2,
    input  cps_pkg::mmr_addr_t   addr_prio3,
    input  cps_pkg::mmr_addr_t   addr_in2,
    input  cps_pkg::mmr_addr_t   addr_in3,
    input  cps_pkg::mmr_addr_t   addr_pal_page,
    input  logic [7:0]           cpsb_id,
    input  cps_pkg::input_mode_t input_mode,
    input  logic [3:0]           start_button,
    input  logic [3:0]           coin_input,
    input  logic [9:0]           joystick1,
    input  logic [9:0]           joystick2,
    input  logic [9:0]           joystick3,
    input  logic [9:0]           joystick4,
    output cps_pkg::word_t       mmr_dout,
    output cps_pkg::word_t       layer_ctrl,
    output cps_pkg::word_t       prio0,
    output cps_pkg::word_t       prio1,
    output cps_pkg::word_t       prio2,
    output cps_pkg::word_t       prio3,
    output logic [5:0]           pal_page_en
);

    cps_pkg::word_t mult1;
    cps_pkg::word_t mult2;
    cps_pkg::word_t rslt0;
    cps_pkg::word_t rslt1;
    cps_pkg::word_t rd_data;
    logic [7:0]     in2;
    logic [7:0]     in3;
    logic [12:0]    hit;
    logic           wr;

    // slot match, an all-ones bus address never hits anything
    function automatic logic slot_hit(cps_pkg::mmr_addr_t a, cps_pkg::mmr_addr_t slot,
                                      logic usable);
        return usable && (a == slot) && !(&a);
    endfunction

    assign hit[0]  = slot_hit(addr, addr_id, 1'b1);
    assign hit[1]  = slot_hit(addr, addr_mult1, addr_mult1 != `CPS_ADDR_LOCKED);
    assign hit[2]  = slot_hit(addr, addr_mult2, addr_mult2 != `CPS_ADDR_LOCKED);
    assign hit[3]  = slot_hit(addr, addr_rslt0, addr_rslt0 != `CPS_ADDR_LOCKED);
    assign hit[4]  = slot_hit(addr, addr_rslt1, addr_rslt1 != `CPS_ADDR_LOCKED);
    assign hit[5]  = slot_hit(addr, addr_layer, 1'b1);
    assign hit[6]  = slot_hit(addr, addr_prio0, addr_prio0 != `CPS_ADDR_LOCKED);
    assign hit[7]  = slot_hit(addr, addr_prio1, addr_prio1 != `CPS_ADDR_LOCKED);
    assign hit[8]  = slot_hit(addr, addr_prio2, addr_prio2 != `CPS_ADDR_LOCKED);
    assign hit[9]  = slot_hit(addr, addr_prio3, addr_prio3 != `CPS_ADDR_LOCKED);
    assign hit[10] = slot_hit(addr, addr_pal_page, 1'b1);
    assign hit[11] = slot_hit(addr, addr_in2, addr_in2 != `CPS_ADDR_NONE);
    assign hit[12] = slot_hit(addr, addr_in3, addr_in3 != `CPS_ADDR_NONE);

    // only full-word writes land
    assign wr = ppu2_cs && (dsn == 2'b00);

    // product lags the operands by one clock
    always_ff @(posedge clk) begin
        {rslt1, rslt0} <= mult1 * mult2;
    end

    // player inputs sampled every clock
    always_ff @(posedge clk) begin
        in3 <= {start_button[3], coin_input[3], joystick4[5:0]};
        if (input_mode == cps_pkg::INPUT_6BTN) begin
            in2 <= {1'b1, joystick2[9:7], 1'b1, joystick1[9:7]};
        end else begin
            in2 <= {start_button[2], coin_input[2], joystick3[5:0]};
        end
    end

    always_comb begin
        rd_data = `CPS_MMR_IDLE;
        if (hit[0])       rd_data = {4'h0, cpsb_id[7:4], 4'h0, cpsb_id[3:0]};
        else if (hit[1])  rd_data = mult1;
        else if (hit[2])  rd_data = mult2;
        else if (hit[3])  rd_data = rslt0;
        else if (hit[4])  rd_data = rslt1;
        else if (hit[5])  rd_data = layer_ctrl;
        else if (hit[6])  rd_data = prio0;
        else if (hit[7])  rd_data = prio1;
        else if (hit[8])  rd_data = prio2;
        else if (hit[9])  rd_data = prio3;
        else if (hit[10]) rd_data = {10'd0, pal_page_en};
        else if (hit[11]) rd_data = {in2, in2};
        else if (hit[12]) rd_data = {in3, in3};
    end

    // multiplier operands
    always_ff @(posedge clk) begin
        if (wr && hit[1]) mult1 <= cpu_dout;
        if (wr && hit[2]) mult2 <= cpu_dout;
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mmr_dout    <= `CPS_MMR_IDLE;
            layer_ctrl  <= `CPS_LAYER_CTRL_RST;
            prio0       <= '0;
            prio1       <= '0;
            prio2       <= '0;
            prio3       <= '0;
            pal_page_en <= `CPS_PAL_PAGE_RST;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_data;
            if (wr && hit[5])  layer_ctrl  <= cpu_dout;
            if (wr && hit[6])  prio0       <= cpu_dout;
            if (wr && hit[7])  prio1       <= cpu_dout;
            if (wr && hit[8])  prio2       <= cpu_dout;
            if (wr && hit[9])  prio3       <= cpu_dout;
            if (wr && hit[10]) pal_page_en <= cpu_dout[5:0];
        end
    end

    // a game table with two slots on one address would make the read mux ambiguous
    a_single_slot: assert property (
        @(posedge clk) disable iff (reg_rst) ppu2_cs |-> $onehot0(hit));

endmodule

//--- cps_cfg_chain.sv
// per-game configuration shift chain, decoded into cps-b register slots and rom mapper levels
`timescale 1ns/100ps
`include "cps_params.svh"

module cps_cfg_chain (
    input  logic                 clk,
    input  logic                 cfg_we,
    input  logic [7:0]           cfg_data,
    output cps_pkg::mmr_addr_t   addr_id,
    output cps_pkg::mmr_addr_t   addr_mult1,
    output cps_pkg::mmr_addr_t   addr_mult2,
    output cps_pkg::mmr_addr_t   addr_rslt0,
    output cps_pkg::mmr_addr_t   addr_rslt1,
    output cps_pkg::mmr_addr_t   addr_layer,
    output cps_pkg::mmr_addr_t   addr_prio0,
    output cps_pkg::mmr_addr_t   addr_prio1,
    output cps_pkg::mmr_addr_t   addr_prio2,
    output cps_pkg::mmr_addr_t   addr_prio3,
    output cps_pkg::mmr_addr_t   addr_in2,
    output cps_pkg::mmr_addr_t   addr_in3,
    output cps_pkg::mmr_addr_t   addr_pal_page,
    output logic [7:0]           cpsb_id,
    output logic [7:0]           layer_mask0,
    output logic [7:0]           layer_mask1,
    output logic [7:0]           layer_mask2,
    output logic [7:0]           layer_mask3,
    output logic [5:0]           game,
    output cps_pkg::word_t       bank_offset,
    output cps_pkg::word_t       bank_mask,
    output cps_pkg::input_mode_t input_mode,
    output logic                 cpu_speed,
    output logic                 charger
);

    logic [7:0] cfg [`CPS_REGSIZE];

    // bytes enter at the top and walk down, so the first byte written ends in slot 0
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            for (int i = 0; i < `CPS_REGSIZE - 1; i++) begin
                cfg[i] <= cfg[i + 1];
            end
            cfg[`CPS_REGSIZE - 1] <= cfg_data;
        end
    end

    // slots hold byte addresses, the bus uses word addresses
    assign addr_id       = cfg[0][5:1];
    assign cpsb_id       = cfg[1];
    assign addr_mult1    = cfg[2][5:1];
    assign addr_mult2    = cfg[3][5:1];
    assign addr_rslt0    = cfg[4][5:1];
    assign addr_rslt1    = cfg[5][5:1];
    assign addr_layer    = cfg[6][5:1];
    assign addr_prio0    = cfg[7][5:1];
    assign addr_prio1    = cfg[8][5:1];
    assign addr_prio2    = cfg[9][5:1];
    assign addr_prio3    = cfg[10][5:1];
    assign addr_in2      = cfg[11][5:1];
    assign addr_in3      = cfg[12][5:1];
    assign addr_pal_page = cfg[13][5:1];

    // layer 4 shares mask 3 on the video side
    assign layer_mask0   = cfg[14];
    assign layer_mask1   = cfg[15];
    assign layer_mask2   = cfg[16];
    assign layer_mask3   = cfg[17];

    // mapper bytes
    assign game          = cfg[18][5:0];
    assign bank_offset   = {cfg[20], cfg[19]};
    assign bank_mask     = {cfg[22], cfg[21]};
    assign charger       = cfg[23][7];
    assign input_mode    = cps_pkg::input_mode_t'(cfg[23][3]);
    assign cpu_speed     = cfg[23][0];

    // an unknown byte would poison the whole address map
    a_cfg_data_known: assert property (@(posedge clk) cfg_we |-> !$isunknown(cfg_data));

endmodule

//--- cps_mmr_top.sv
// cps-a/cps-b register subsystem: configuration chain beside the two register banks
`timescale 1ns/100ps

module cps_mmr_top (
    input  logic               clk,
    input  logic               reg_rst,
    input  logic               ppu1_cs,
    input  logic               ppu2_cs,
    input  cps_pkg::mmr_addr_t addr,
    input  logic [1:0]         dsn,
    input  cps_pkg::word_t     cpu_dout,
    output cps_pkg::word_t     mmr_dout,
    input  logic               cfg_we,
    input  logic [7:0]         cfg_data,
    input  logic [3:0]         start_button,
    input  logic [3:0]         coin_input,
    input  logic [9:0]         joystick1,
    input  logic [9:0]         joystick2,
    input  logic [9:0]         joystick3,
    input  logic [9:0]         joystick4,
    output cps_pkg::word_t     vram_obj_base,
    output cps_pkg::word_t     vram1_base,
    output cps_pkg::word_t     vram2_base,
    output cps_pkg::word_t     vram3_base,
    output cps_pkg::word_t     vram_row_base,
    output cps_pkg::word_t     pal_base,
    output cps_pkg::word_t     hpos1,
    output cps_pkg::word_t     hpos2,
    output cps_pkg::word_t     hpos3,
    output cps_pkg::word_t     vpos1,
    output cps_pkg::word_t     vpos2,
    output cps_pkg::word_t     vpos3,
    output cps_pkg::word_t     hstar1,
    output cps_pkg::word_t     hstar2,
    output cps_pkg::word_t     vstar1,
    output cps_pkg::word_t     vstar2,
    output cps_pkg::word_t     row_offset,
    output cps_pkg::word_t     ppu_ctrl,
    output logic               pal_copy,
    output logic               obj_dma_ok,
    output cps_pkg::word_t     layer_ctrl,
    output cps_pkg::word_t     prio0,
    output cps_pkg::word_t     prio1,
    output cps_pkg::word_t     prio2,
    output cps_pkg::word_t     prio3,
    output logic [5:0]         pal_page_en,
    output logic [7:0]         layer_mask0,
    output logic [7:0]         layer_mask1,
    output logic [7:0]         layer_mask2,
    output logic [7:0]         layer_mask3,
    output logic [5:0]         game,
    output cps_pkg::word_t     bank_offset,
    output cps_pkg::word_t     bank_mask,
    output logic               cpu_speed,
    output logic               charger
);

    // cps-b address map and mode, levels from the chain
    cps_pkg::mmr_addr_t   addr_id;
    cps_pkg::mmr_addr_t   addr_mult1;
    cps_pkg::mmr_addr_t   addr_mult2;
    cps_pkg::mmr_addr_t   addr_rslt0;
    cps_pkg::mmr_addr_t   addr_rslt1;
    cps_pkg::mmr_addr_t   addr_layer;
    cps_pkg::mmr_addr_t   addr_prio0;
    cps_pkg::mmr_addr_t   addr_prio1;
    cps_pkg::mmr_addr_t   addr_prio2;
    cps_pkg::mmr_addr_t   addr_prio3;
    cps_pkg::mmr_addr_t   addr_in2;
    cps_pkg::mmr_addr_t   addr_in3;
    cps_pkg::mmr_addr_t   addr_pal_page;
    logic [7:0]           cpsb_id;
    cps_pkg::input_mode_t input_mode;

    // port names match the top-level nets one to one
    cps_cfg_chain i_cps_cfg_chain (.*);

    cps_a_regs i_cps_a_regs (.*);

    cps_b_regs i_cps_b_regs (.*);

endmodule

//--- cps_params.svh
// register block constants (config size, address map, slot lock codes, reset values), included by rtl
`ifndef CPS_PARAMS_SVH
`define CPS_PARAMS_SVH

// length of the per-game configuration string in bytes
`define CPS_REGSIZE        24

// slot lock codes
`define CPS_ADDR_LOCKED    5'h1f
`define CPS_ADDR_NONE      5'h00

// cps-a word offsets
`define CPS_A_OBJ_BASE     5'h00
`define CPS_A_VRAM1_BASE   5'h01
`define CPS_A_VRAM2_BASE   5'h02
`define CPS_A_VRAM3_BASE   5'h03
`define CPS_A_ROW_BASE     5'h04
`define CPS_A_PAL_BASE     5'h05
`define CPS_A_HPOS1        5'h06
`define CPS_A_VPOS1        5'h07
`define CPS_A_HPOS2        5'h08
`define CPS_A_VPOS2        5'h09
`define CPS_A_HPOS3        5'h0a
`define CPS_A_VPOS3        5'h0b
`define CPS_A_HSTAR1       5'h0c
`define CPS_A_VSTAR1       5'h0d
`define CPS_A_HSTAR2       5'h0e
`define CPS_A_VSTAR2       5'h0f
`define CPS_A_ROW_OFFSET   5'h10
`define CPS_A_VIDEO_CTRL   5'h11

// reset values
`define CPS_LAYER_CTRL_RST 16'h1b60
`define CPS_PAL_PAGE_RST   6'h3f
`define CPS_MMR_IDLE       16'hffff

`endif

//--- cps_pkg.sv
// shared word, bus address and input-mode types for the cps register block and its testbench
package cps_pkg;

    // one cpu bus word or register
    typedef logic [15:0] word_t;

    // word address on the cpu bus, byte address bits 5..1
    typedef logic [4:0] mmr_addr_t;

    // what the second extra input port returns
    typedef enum logic {
        INPUT_3P   = 1'b0,
        INPUT_6BTN = 1'b1
    } input_mode_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the cps register testbench with verilator, from the project root

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_cps_mmr -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- tb_cps_mmr.sv
// directed testbench for the cps register subsystem, run through verilog.f and run_sim.sh
`timescale 1ns/100ps
`include "cps_params.svh"

module tb_cps_mmr;

    localparam int NUM_A = `CPS_A_VIDEO_CTRL + 1;

    logic               clk;
    logic               reg_rst;
    logic               ppu1_cs;
    logic               ppu2_cs;
    cps_pkg::mmr_addr_t addr;
    logic [1:0]         dsn;
    cps_pkg::word_t     cpu_dout;
    cps_pkg::word_t     mmr_dout;
    logic               cfg_we;
    logic [7:0]         cfg_data;
    logic [3:0]         start_button, coin_input;
    logic [9:0]         joystick1, joystick2, joystick3, joystick4;
    cps_pkg::word_t     vram_obj_base, vram1_base, vram2_base, vram3_base, vram_row_base;
    cps_pkg::word_t     pal_base, hpos1, hpos2, hpos3, vpos1, vpos2, vpos3;
    cps_pkg::word_t     hstar1, hstar2, vstar1, vstar2, row_offset, ppu_ctrl;
    logic               pal_copy, obj_dma_ok;
    cps_pkg::word_t     layer_ctrl, prio0, prio1, prio2, prio3;
    logic [5:0]         pal_page_en;
    logic [7:0]         layer_mask0, layer_mask1, layer_mask2, layer_mask3;
    logic [5:0]         game;
    cps_pkg::word_t     bank_offset, bank_mask;
    logic               cpu_speed, charger;

    // cps-a outputs flattened by offset, offset 0 in the low word
    logic [NUM_A*16-1:0] a_flat;
    logic [63:0]         prio_flat;
    cps_pkg::word_t      a_model [NUM_A];
    logic [7:0]          cfg_tbl [`CPS_REGSIZE];
    int                  errors;
    int                  err_mark;
    int                  tests_ok;
    int                  tests_bad;

    assign a_flat = {ppu_ctrl, row_offset, vstar2, hstar2, vstar1, hstar1, vpos3, hpos3,
                     vpos2, hpos2, vpos1, hpos1, pal_base, vram_row_base, vram3_base,
                     vram2_base, vram1_base, vram_obj_base};
    assign prio_flat = {prio3, prio2, prio1, prio0};

    cps_mmr_top i_cps_mmr_top (.*);

    always #50 clk = ~clk;

    task automatic flag_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    // game table, slots given as byte addresses
    task automatic build_table(input bit locked, input bit six_btn);
        int i;
        cfg_tbl[0] = 8'h32;
        cfg_tbl[1] = 8'ha5;
        for (i = 2; i <= 13; i++) cfg_tbl[i] = 8'h1c + 8'(2 * i);
        cfg_tbl[11] = 8'h38;
        cfg_tbl[12] = 8'h34;
        for (i = 14; i <= 17; i++) cfg_tbl[i] = 8'(17 * (i - 13));
        cfg_tbl[18] = 8'h2b;
        cfg_tbl[19] = 8'h34;
        cfg_tbl[20] = 8'h12;
        cfg_tbl[21] = 8'hf0;
        cfg_tbl[22] = 8'h0f;
        cfg_tbl[23] = six_btn ? 8'h89 : 8'h81;
        if (locked) begin
            for (i = 2; i <= 10; i++) begin
                if (i != 6) cfg_tbl[i] = 8'h3e;
            end
            cfg_tbl[11] = 8'h00;
            cfg_tbl[12] = 8'h00;
        end
    endtask

    task automatic cfg_load;
        int i;
        for (i = 0; i < `CPS_REGSIZE; i++) begin
            @(posedge clk);
            #10;
            cfg_we = 1'b1;
            cfg_data = cfg_tbl[i];
        end
        @(posedge clk);
        #10;
        cfg_we = 1'b0;
    endtask

    task automatic cpu_write(input bit to_b, input cps_pkg::mmr_addr_t a, input logic [1:0] sel_n,
                             input cps_pkg::word_t d);
        @(posedge clk);
        #10;
        ppu1_cs = !to_b;
        ppu2_cs = to_b;
        addr = a;
        dsn = sel_n;
        cpu_dout = d;
        @(posedge clk);
        #10;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        dsn = 2'b11;
    endtask

    task automatic cpu_read(input cps_pkg::mmr_addr_t a, output cps_pkg::word_t d);
        @(posedge clk);
        #10;
        ppu2_cs = 1'b1;
        addr = a;
        dsn = 2'b11;
        @(posedge clk);
        #10;
        ppu2_cs = 1'b0;
        d = mmr_dout;
    endtask

    task automatic read_check(input cps_pkg::mmr_addr_t a, input cps_pkg::word_t exp,
                              input string what);
        cps_pkg::word_t rd;
        cpu_read(a, rd);
        if (rd !== exp) flag_error($sformatf("%s at %h read %h, expected %h", what, a, rd, exp));
    endtask

    // rise_at counts cycles from the end of the write, 0 when the strobe never came
    task automatic wait_pulse(input bit want_copy, input int limit, output int rise_at,
                              output int width, output bit other_seen);
        int n;
        rise_at = 0;
        width = 0;
        other_seen = 1'b0;
        for (n = 1; n <= limit && rise_at == 0; n++) begin
            @(posedge clk);
            #10;
            if (want_copy ? pal_copy : obj_dma_ok) rise_at = n;
            if (want_copy ? obj_dma_ok : pal_copy) other_seen = 1'b1;
        end
        for (n = 0; n < limit && rise_at != 0 && width == n; n++) begin
            width++;
            @(posedge clk);
            #10;
            if (!(want_copy ? pal_copy : obj_dma_ok)) break;
        end
    endtask

    task automatic compare_a_regs(input string when);
        int j;
        for (j = 0; j < NUM_A; j++) begin
            if (a_flat[j*16 +: 16] !== a_model[j])
                flag_error($sformatf("cps-a offset %0d is %h, expected %h after %s",
                                     j, a_flat[j*16 +: 16], a_model[j], when));
        end
    endtask

    task automatic test_reset_values;
        err_mark = errors;
        if (a_flat !== '0) flag_error("cps-a registers not zero after reset");
        if (pal_copy !== 1'b0 || obj_dma_ok !== 1'b0) flag_error("strobe high after reset");
        if (mmr_dout !== 16'hffff) flag_error($sformatf("mmr_dout %h after reset", mmr_dout));
        if (prio_flat !== '0) flag_error("priority masks not zero after reset");
        if (layer_ctrl !== `CPS_LAYER_CTRL_RST) flag_error("layer control reset value wrong");
        if (pal_page_en !== `CPS_PAL_PAGE_RST) flag_error("palette page reset value wrong");
        end_test("reset values");
    endtask

    task automatic test_cfg_decode;
        err_mark = errors;
        build_table(1'b0, 1'b0);
        cfg_load();
        if (game !== cfg_tbl[18][5:0]) flag_error($sformatf("game is %h", game));
        if (bank_offset !== {cfg_tbl[20], cfg_tbl[19]})
            flag_error($sformatf("bank_offset is %h", bank_offset));
        if (bank_mask !== {cfg_tbl[22], cfg_tbl[21]})
            flag_error($sformatf("bank_mask is %h", bank_mask));
        if ({layer_mask3, layer_mask2, layer_mask1, layer_mask0} !==
            {cfg_tbl[17], cfg_tbl[16], cfg_tbl[15], cfg_tbl[14]})
            flag_error("layer masks do not match bytes 14 to 17");
        if (cpu_speed !== cfg_tbl[23][0] || charger !== cfg_tbl[23][7])
            flag_error("cpu_speed or charger does not match byte 23");
        read_check(cfg_tbl[0][5:1], {4'h0, cfg_tbl[1][7:4], 4'h0, cfg_tbl[1][3:0]}, "chip id");
        end_test("configuration decode");
    endtask

    task automatic test_a_writes;
        int i;
        int k;
        logic [1:0] sel_n;
        cps_pkg::word_t d;
        err_mark = errors;
        for (i = 0; i < NUM_A; i++) a_model[i] = '0;
        for (i = 0; i < NUM_A; i++) begin
            for (k = 0; k < 4; k++) begin
                sel_n = k[1:0];
                d = 16'($urandom);
                cpu_write(1'b0, i[4:0], sel_n, d);
                // lanes with a low select take the new byte
                if (!sel_n[1]) a_model[i][15:8] = d[15:8];
                if (!sel_n[0]) a_model[i][7:0] = d[7:0];
                compare_a_regs($sformatf("write to %0d with dsn %b", i, sel_n));
            end
        end
        cpu_write(1'b0, 5'h12, 2'b00, 16'($urandom));
        cpu_write(1'b0, 5'h1f, 2'b00, 16'($urandom));
        compare_a_regs("unmapped writes");
        end_test("cps-a byte writes");
    endtask

    task automatic test_pulses;
        int rise;
        int width;
        bit other;
        err_mark = errors;
        cpu_write(1'b0, `CPS_A_PAL_BASE, 2'b00, 16'h9100);
        wait_pulse(1'b1, 8, rise, width, other);
        if (rise == 0) flag_error("pal_copy never rose within 8 cycles of the palette write");
        if (rise > 1) flag_error($sformatf("pal_copy rose %0d cycles after cs fell", rise));
        if (rise != 0 && width != 1) flag_error($sformatf("pal_copy lasted %0d cycles", width));
        if (other) flag_error("obj_dma_ok pulsed after a palette base write");
        cpu_write(1'b0, `CPS_A_OBJ_BASE, 2'b00, 16'h9200);
        wait_pulse(1'b0, 8, rise, width, other);
        if (rise == 0) flag_error("obj_dma_ok never rose within 8 cycles of the object write");
        if (rise > 1) flag_error($sformatf("obj_dma_ok rose %0d cycles after cs fell", rise));
        if (rise != 0 && width != 1) flag_error($sformatf("obj_dma_ok lasted %0d cycles", width));
        if (other) flag_error("pal_copy pulsed after an object base write");
        cpu_write(1'b0, `CPS_A_HPOS1, 2'b00, 16'h0123);
        wait_pulse(1'b1, 4, rise, width, other);
        if (rise != 0 || other) flag_error("a strobe pulsed after a scroll register write");
        end_test("copy and dma pulses");
    endtask

    task automatic test_relocated;
        int p;
        cps_pkg::word_t d;
        cps_pkg::word_t prio_exp [4];
        err_mark = errors;
        d = 16'($urandom);
        cpu_write(1'b1, cfg_tbl[6][5:1], 2'b00, d);
        if (layer_ctrl !== d) flag_error($sformatf("layer_ctrl %h, expected %h", layer_ctrl, d));
        read_check(cfg_tbl[6][5:1], d, "layer control");
        cpu_write(1'b1, cfg_tbl[6][5:1], 2'b01, ~d);
        cpu_write(1'b1, cfg_tbl[6][5:1], 2'b10, ~d);
        if (layer_ctrl !== d) flag_error("layer_ctrl changed by a single-byte write");
        for (p = 0; p < 4; p++) begin
            prio_exp[p] = 16'($urandom);
            cpu_write(1'b1, cfg_tbl[7 + p][5:1], 2'b00, prio_exp[p]);
        end
        if (prio_flat !== {prio_exp[3], prio_exp[2], prio_exp[1], prio_exp[0]})
            flag_error($sformatf("priority masks are %h", prio_flat));
        for (p = 0; p < 4; p++) read_check(cfg_tbl[7 + p][5:1], prio_exp[p], "priority mask");
        d = 16'($urandom);
        cpu_write(1'b1, cfg_tbl[13][5:1], 2'b00, d);
        if (pal_page_en !== d[5:0]) flag_error($sformatf("pal_page_en is %h", pal_page_en));
        read_check(cfg_tbl[13][5:1], {10'd0, d[5:0]}, "palette page");
        read_check(5'h05, 16'hffff, "unmapped address");
        read_check(5'h1f, 16'hffff, "all-ones address");
        end_test("relocated registers");
    endtask

    task automatic test_locked;
        int a;
        logic [63:0] prio_keep;
        err_mark = errors;
        build_table(1'b1, 1'b0);
        cfg_load();
        prio_keep = prio_flat;
        // old multiplier and priority slots, the lock code and the disabled input address
        for (a = 5'h10; a <= 5'h1f; a++) begin
            if (a != 5'h14 && (a <= 5'h18 || a == 5'h1f)) begin
                cpu_write(1'b1, a[4:0], 2'b00, 16'($urandom));
                read_check(a[4:0], 16'hffff, "locked slot");
            end
        end
        cpu_write(1'b1, 5'h00, 2'b00, 16'($urandom));
        read_check(5'h00, 16'hffff, "disabled input slot");
        if (prio_flat !== prio_keep) flag_error("priority masks changed with locked slots");
        end_test("slot locking");
    endtask

    task automatic set_inputs;
        @(posedge clk);
        #10;
        start_button = 4'($urandom);
        coin_input = 4'($urandom);
        joystick1 = 10'($urandom);
        joystick2 = 10'($urandom);
        joystick3 = 10'($urandom);
        joystick4 = 10'($urandom);
    endtask

    task automatic test_mult_inputs;
        cps_pkg::word_t m1;
        cps_pkg::word_t m2;
        logic [31:0] prod;
        logic [7:0] in2_exp;
        logic [7:0] in3_exp;
        err_mark = errors;
        build_table(1'b0, 1'b0);
        cfg_load();
        m1 = 16'($urandom);
        m2 = 16'($urandom);
        cpu_write(1'b1, cfg_tbl[2][5:1], 2'b00, m1);
        cpu_write(1'b1, cfg_tbl[3][5:1], 2'b00, m2);
        prod = {16'd0, m1} * {16'd0, m2};
        read_check(cfg_tbl[4][5:1], prod[15:0], "product low half");
        read_check(cfg_tbl[5][5:1], prod[31:16], "product high half");
        read_check(cfg_tbl[2][5:1], m1, "first operand");
        read_check(cfg_tbl[3][5:1], m2, "second operand");
        set_inputs();
        in3_exp = {start_button[3], coin_input[3], joystick4[5:0]};
        in2_exp = {start_button[2], coin_input[2], joystick3[5:0]};
        read_check(cfg_tbl[11][5:1], {in2_exp, in2_exp}, "three-player input");
        read_check(cfg_tbl[12][5:1], {in3_exp, in3_exp}, "fourth-player input");
        build_table(1'b0, 1'b1);
        cfg_load();
        in2_exp = {1'b1, joystick2[9:7], 1'b1, joystick1[9:7]};
        read_check(cfg_tbl[11][5:1], {in2_exp, in2_exp}, "six-button input");
        read_check(cfg_tbl[12][5:1], {in3_exp, in3_exp}, "fourth-player input");
        end_test("multiplier and inputs");
    endtask

    initial begin
        void'($urandom(44775));
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        clk = 1'b0;
        reg_rst = 1'b1;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        addr = '0;
        dsn = 2'b11;
        cpu_dout = '0;
        cfg_we = 1'b0;
        cfg_data = '0;
        start_button = '0;
        coin_input = '0;
        joystick1 = '0;
        joystick2 = '0;
        joystick3 = '0;
        joystick4 = '0;
        repeat (4) @(posedge clk);
        #10;
        reg_rst = 1'b0;
        test_reset_values();
        test_cfg_decode();
        test_a_writes();
        test_pulses();
        test_relocated();
        test_locked();
        test_mult_inputs();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
cps_pkg.sv
cps_cfg_chain.sv
cps_a_regs.sv
cps_b_regs.sv
cps_mmr_top.sv
tb_cps_mmr.sv
